// File: filelist.f
hdl/acq_ctrl_pkg.sv
hdl/acq_data_pkg.sv
hdl/acq_cmd_regs.sv
hdl/acq_sequencer.sv
hdl/adc_capture.sv
hdl/sample_fifo.sv
hdl/udp_tx_framer.sv
hdl/acq_top.sv
verif/acq_tb.sv

// File: hdl/acq_cmd_regs.sv
`timescale 1ns/10ps
`default_nettype none

module acq_cmd_regs import acq_ctrl_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_run,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    output logic        cmd_start,
    output logic        cmd_stop,
    output logic [7:0]  pkt_count,
    output logic [15:0] gain
);

    // Position of the next byte within a command payload.
    typedef enum logic [1:0] {
        POS_OP,
        POS_COUNT,
        POS_GAIN
    } byte_pos_e;

    byte_pos_e  pos;
    logic [7:0] count_buf; // Count byte of a START that waits for its gain byte.

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            pos       <= POS_OP;
            cmd_start <= 1'b0;
            cmd_stop  <= 1'b0;
            pkt_count <= 8'd0;
            gain      <= 16'd0;
        end else begin
            cmd_start <= 1'b0;
            cmd_stop  <= 1'b0;
            if (rx_valid) begin
                case (pos)
                    POS_OP: begin
                        if (rx_data == CMD_START) pos <= POS_COUNT;
                        else if (rx_data == CMD_STOP) cmd_stop <= 1'b1;
                    end
                    POS_COUNT: pos <= POS_GAIN;
                    POS_GAIN: begin
                        pos <= POS_OP;
                        if (count_buf != 8'd0) begin // An empty packet size drops the START.
                            cmd_start <= 1'b1;
                            pkt_count <= count_buf;
                            gain      <= {8'd0, rx_data};
                        end
                    end
                    default: pos <= POS_OP;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rx_valid && pos == POS_COUNT) count_buf <= rx_data;
    end

endmodule

`default_nettype wire

// File: hdl/acq_ctrl_pkg.sv
`default_nettype none

package acq_ctrl_pkg;

    ////////////////////////////////////////
    // Sequencer states.
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        MAIN_IDLE  = 2'd0,
        MAIN_RESET = 2'd1,
        MAIN_INIT  = 2'd2,
        MAIN_WORK  = 2'd3
    } main_state_e;

    typedef enum logic [2:0] {
        INIT_IDLE = 3'd0,
        INIT_FFCK = 3'd1, // Wait for an empty sample FIFO.
        INIT_ADCK = 3'd2, // ADC identity check.
        INIT_CONF = 3'd3, // Gain write.
        INIT_LAST = 3'd4
    } init_state_e;

    typedef enum logic [1:0] {
        ADC_IDLE = 2'd0,
        ADC_WAIT = 2'd1,
        ADC_READ = 2'd2,
        ADC_LAST = 2'd3
    } adc_state_e;

    typedef enum logic [2:0] {
        ETH_IDLE = 3'd0,
        ETH_CKGN = 3'd1,
        ETH_CKDN = 3'd2,
        ETH_NMCK = 3'd3,
        ETH_SEND = 3'd4
    } eth_state_e;

    ////////////////////////////////////////
    // Commands and ADC registers.
    ////////////////////////////////////////

    typedef enum logic [7:0] {
        CMD_START = 8'h01,
        CMD_STOP  = 8'h02
    } cmd_op_e;

    typedef enum logic [1:0] {
        ADDR_ID   = 2'd0,
        ADDR_CONF = 2'd1,
        ADDR_DATA = 2'd2
    } adc_addr_e;

    localparam logic [7:0] PKT_MARK = 8'hA5; // Upper byte of every header beat.

endpackage

`default_nettype wire

// File: hdl/acq_data_pkg.sv
`default_nettype none

package acq_data_pkg;

    typedef logic [15:0] sample_t;

    // One beat of the transmit stream towards the MAC.
    typedef struct packed {
        logic        valid;
        logic        last;
        logic [15:0] data;
    } tx_beat_t;

    // Parallel register bus of the ADC.
    typedef struct packed {
        logic                    cs;
        logic                    rd;
        logic                    wr;
        acq_ctrl_pkg::adc_addr_e addr;
        logic [15:0]             wdata;
    } adc_bus_t;

    typedef struct packed {
        logic       running;
        logic       id_error;
        logic [7:0] seq;      // Sequence number of the next packet.
    } acq_status_t;

endpackage

`default_nettype wire

// File: hdl/acq_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module acq_sequencer import acq_ctrl_pkg::*; #(
    parameter int RESET_CYCLES = 4
) (
    input  logic       sys_clk,
    input  logic       rst_run,
    input  logic       cmd_start,
    input  logic       cmd_stop,
    input  logic [7:0] pkt_count,
    input  logic       fifo_empty,
    input  logic       chk_done,
    input  logic       id_ok,
    input  logic       conf_done,
    input  logic       read_done,
    input  logic       adc_drdy,
    input  logic       tx_done,
    output logic       run_clear,
    output logic       chk_go,
    output logic       conf_go,
    output logic       read_go,
    output logic       send_go,
    output logic       running,
    output logic       id_error
);

    localparam logic [7:0] RST_LAST = 8'(RESET_CYCLES - 1);

    main_state_e main_state, main_next;
    init_state_e init_state, init_next;
    adc_state_e  adc_state, adc_next;
    eth_state_e  eth_state, eth_next;

    logic [7:0] rst_cnt;
    logic [7:0] smp_cnt;   // Samples already taken for the current packet.
    logic       drdy_prev;
    logic       id_fail;
    logic       last_sample;

    assign run_clear   = (main_state == MAIN_RESET);
    assign running     = (main_state == MAIN_WORK);
    assign id_fail     = (init_state == INIT_ADCK) && chk_done && !id_ok;
    assign last_sample = (smp_cnt == pkt_count - 8'd1);

    // Each go strobe marks the cycle in which its machine leaves the waiting state.
    assign chk_go  = (init_state == INIT_FFCK) && fifo_empty;
    assign conf_go = (init_state == INIT_ADCK) && chk_done && id_ok;
    assign read_go = (adc_state == ADC_WAIT) && adc_drdy && !drdy_prev &&
                     (eth_state == ETH_CKGN) && running;
    assign send_go = (eth_state == ETH_NMCK) && last_sample && running;

    ////////////////////////////////////////
    // Next-state logic.
    ////////////////////////////////////////

    always_comb begin
        main_next = main_state;
        case (main_state)
            MAIN_RESET: if (rst_cnt == RST_LAST) main_next = MAIN_INIT;
            MAIN_INIT: begin
                if (id_fail) main_next = MAIN_IDLE;
                else if (init_state == INIT_LAST) main_next = MAIN_WORK;
            end
            default: main_next = main_state;
        endcase
        if (cmd_stop) main_next = MAIN_IDLE;
        if (cmd_start) main_next = MAIN_RESET;
    end

    always_comb begin
        init_next = init_state;
        case (init_state)
            INIT_IDLE: init_next = INIT_FFCK;
            INIT_FFCK: if (chk_go) init_next = INIT_ADCK;
            INIT_ADCK: begin
                if (conf_go) init_next = INIT_CONF;
                else if (id_fail) init_next = INIT_IDLE;
            end
            INIT_CONF: if (conf_done) init_next = INIT_LAST;
            default:   init_next = init_state;
        endcase
        if (main_state != MAIN_INIT) init_next = INIT_IDLE;
    end

    always_comb begin
        adc_next = adc_state;
        case (adc_state)
            ADC_IDLE: adc_next = ADC_WAIT;
            ADC_WAIT: if (read_go) adc_next = ADC_READ;
            ADC_READ: if (read_done) adc_next = ADC_LAST;
            ADC_LAST: if (eth_state == ETH_CKDN) adc_next = ADC_WAIT;
            default:  adc_next = ADC_IDLE;
        endcase
        if (!running) adc_next = ADC_IDLE;
    end

    always_comb begin
        eth_next = eth_state;
        case (eth_state)
            ETH_IDLE: eth_next = ETH_CKGN;
            ETH_CKGN: if (adc_state == ADC_LAST) eth_next = ETH_CKDN;
            ETH_CKDN: if (adc_state != ADC_LAST) eth_next = ETH_NMCK;
            ETH_NMCK: eth_next = send_go ? ETH_SEND : ETH_CKGN;
            ETH_SEND: if (tx_done) eth_next = ETH_CKGN;
            default:  eth_next = ETH_IDLE;
        endcase
        if (!running && eth_state != ETH_SEND) eth_next = ETH_IDLE; // A packet in flight completes.
    end

    ////////////////////////////////////////
    // State registers.
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            main_state <= MAIN_IDLE;
            rst_cnt    <= 8'd0;
            id_error   <= 1'b0;
            drdy_prev  <= 1'b0;
        end else begin
            main_state <= main_next;
            rst_cnt    <= run_clear ? rst_cnt + 8'd1 : 8'd0;
            drdy_prev  <= adc_drdy;
            if (cmd_start) id_error <= 1'b0;
            else if (id_fail) id_error <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            init_state <= INIT_IDLE;
            adc_state  <= ADC_IDLE;
            eth_state  <= ETH_IDLE;
            smp_cnt    <= 8'd0;
        end else if (run_clear) begin
            init_state <= INIT_IDLE;
            adc_state  <= ADC_IDLE;
            eth_state  <= ETH_IDLE;
            smp_cnt    <= 8'd0;
        end else begin
            init_state <= init_next;
            adc_state  <= adc_next;
            eth_state  <= eth_next;
            if (eth_state == ETH_NMCK) smp_cnt <= last_sample ? 8'd0 : smp_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/acq_top.sv
`timescale 1ns/10ps
`default_nettype none

module acq_top import acq_data_pkg::*; #(
    parameter logic [15:0] ADC_ID        = 16'h5A17,
    parameter int          RESET_CYCLES  = 4,
    parameter int          ACCESS_CYCLES = 2,
    parameter int          FIFO_DEPTH    = 256
) (
    input  logic        sys_clk,
    input  logic        rst_run,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    input  sample_t     adc_rdata,
    input  logic        adc_drdy,
    input  logic        tx_done,
    output adc_bus_t    adc,
    output tx_beat_t    tx,
    output acq_status_t status
);

    logic        cmd_start;
    logic        cmd_stop;
    logic [7:0]  pkt_count;
    logic [15:0] gain;
    logic        run_clear;
    logic        chk_go;
    logic        conf_go;
    logic        read_go;
    logic        send_go;
    logic        running;
    logic        id_error;
    logic        chk_done;
    logic        id_ok;
    logic        conf_done;
    logic        read_done;
    logic        fifo_wr;
    logic        fifo_rd;
    logic        fifo_empty;
    sample_t     fifo_wdata;
    sample_t     fifo_rdata;
    logic [7:0]  seq;

    assign status = '{running: running, id_error: id_error, seq: seq};

    acq_cmd_regs u_cmd_regs (
        .sys_clk   (sys_clk),
        .rst_run   (rst_run),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .cmd_start (cmd_start),
        .cmd_stop  (cmd_stop),
        .pkt_count (pkt_count),
        .gain      (gain)
    );

    acq_sequencer #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_sequencer (
        .sys_clk    (sys_clk),
        .rst_run    (rst_run),
        .cmd_start  (cmd_start),
        .cmd_stop   (cmd_stop),
        .pkt_count  (pkt_count),
        .fifo_empty (fifo_empty),
        .chk_done   (chk_done),
        .id_ok      (id_ok),
        .conf_done  (conf_done),
        .read_done  (read_done),
        .adc_drdy   (adc_drdy),
        .tx_done    (tx_done),
        .run_clear  (run_clear),
        .chk_go     (chk_go),
        .conf_go    (conf_go),
        .read_go    (read_go),
        .send_go    (send_go),
        .running    (running),
        .id_error   (id_error)
    );

    ////////////////////////////////////////
    // Data path.
    ////////////////////////////////////////

    adc_capture #(
        .ADC_ID        (ADC_ID),
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_adc_capture (
        .sys_clk    (sys_clk),
        .rst_run    (rst_run),
        .run_clear  (run_clear),
        .chk_go     (chk_go),
        .conf_go    (conf_go),
        .read_go    (read_go),
        .gain       (gain),
        .adc_rdata  (adc_rdata),
        .adc        (adc),
        .chk_done   (chk_done),
        .id_ok      (id_ok),
        .conf_done  (conf_done),
        .read_done  (read_done),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sample_fifo (
        .sys_clk   (sys_clk),
        .rst_run   (rst_run),
        .run_clear (run_clear),
        .wr        (fifo_wr),
        .rd        (fifo_rd),
        .wdata     (fifo_wdata),
        .rdata     (fifo_rdata),
        .empty     (fifo_empty)
    );

    udp_tx_framer u_tx_framer (
        .sys_clk    (sys_clk),
        .rst_run    (rst_run),
        .run_clear  (run_clear),
        .send_go    (send_go),
        .pkt_count  (pkt_count),
        .fifo_rdata (fifo_rdata),
        .fifo_rd    (fifo_rd),
        .tx         (tx),
        .seq        (seq)
    );

endmodule

`default_nettype wire

// File: hdl/adc_capture.sv
`timescale 1ns/10ps
`default_nettype none

module adc_capture import acq_ctrl_pkg::*, acq_data_pkg::*; #(
    parameter logic [15:0] ADC_ID        = 16'h5A17,
    parameter int          ACCESS_CYCLES = 2
) (
    input  logic        sys_clk,
    input  logic        rst_run,
    input  logic        run_clear,
    input  logic        chk_go,
    input  logic        conf_go,
    input  logic        read_go,
    input  logic [15:0] gain,
    input  sample_t     adc_rdata,
    output adc_bus_t    adc,
    output logic        chk_done,
    output logic        id_ok,
    output logic        conf_done,
    output logic        read_done,
    output logic        fifo_wr,
    output sample_t     fifo_wdata
);

    localparam int            CW       = $clog2(ACCESS_CYCLES + 1);
    localparam logic [CW-1:0] ACC_LAST = CW'(ACCESS_CYCLES - 1);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_BUS,  // Chip select active.
        CAP_END   // First cycle with chip select low.
    } cap_state_e;

    cap_state_e    state;
    logic [CW-1:0] acc_cnt;
    logic          bus_end;

    assign bus_end = (state == CAP_BUS) && (acc_cnt == ACC_LAST);

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            state <= CAP_IDLE;
            adc   <= '0;
            id_ok <= 1'b0;
            {chk_done, conf_done, read_done, fifo_wr} <= 4'b0000;
        end else if (run_clear) begin
            state <= CAP_IDLE;
            adc   <= '0;
            id_ok <= 1'b0;
            {chk_done, conf_done, read_done, fifo_wr} <= 4'b0000;
        end else begin
            {chk_done, conf_done, read_done, fifo_wr} <= 4'b0000;
            case (state)
                CAP_IDLE: begin
                    if (chk_go || conf_go || read_go) begin
                        state     <= CAP_BUS;
                        adc.cs    <= 1'b1;
                        adc.rd    <= !conf_go;
                        adc.wr    <= conf_go;
                        adc.addr  <= chk_go ? ADDR_ID : (conf_go ? ADDR_CONF : ADDR_DATA);
                        adc.wdata <= gain;
                    end
                end
                CAP_BUS: begin
                    if (bus_end) begin
                        state  <= CAP_END;
                        adc.cs <= 1'b0;
                        adc.rd <= 1'b0;
                        adc.wr <= 1'b0;
                        if (adc.addr == ADDR_ID) id_ok <= (adc_rdata == ADC_ID);
                    end
                end
                default: begin
                    state     <= CAP_IDLE;
                    chk_done  <= (adc.addr == ADDR_ID);
                    conf_done <= (adc.addr == ADDR_CONF);
                    read_done <= (adc.addr == ADDR_DATA);
                    fifo_wr   <= (adc.addr == ADDR_DATA);
                end
            endcase
        end
    end

    // Access timer and the read data, sampled on the edge where cs drops.
    always_ff @(posedge sys_clk) begin
        acc_cnt <= (state == CAP_BUS) ? acc_cnt + 1'b1 : '0;
        if (bus_end) fifo_wdata <= adc_rdata;
    end

endmodule

`default_nettype wire

// File: hdl/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo import acq_data_pkg::*; #(
    parameter int FIFO_DEPTH = 256 // A power of two, so the pointers wrap by themselves.
) (
    input  logic    sys_clk,
    input  logic    rst_run,
    input  logic    run_clear,
    input  logic    wr,
    input  logic    rd,
    input  sample_t wdata,
    output sample_t rdata,
    output logic    empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    sample_t       mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;
    logic          do_wr;
    logic          do_rd;

    assign empty = (level == '0);
    assign do_wr = wr && (level != (AW+1)'(FIFO_DEPTH)); // Writes to a full buffer are lost.
    assign do_rd = rd && !empty;

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (run_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            level <= level + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_wr) mem[wr_ptr] <= wdata;
        if (do_rd) rdata <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

// File: hdl/udp_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_framer import acq_ctrl_pkg::*, acq_data_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_run,
    input  logic       run_clear,
    input  logic       send_go,
    input  logic [7:0] pkt_count,
    input  sample_t    fifo_rdata,
    output logic       fifo_rd,
    output tx_beat_t   tx,
    output logic [7:0] seq
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEAD,
        TX_BODY
    } frame_state_e;

    frame_state_e state;
    logic [7:0]   left;       // Sample beats still to send, the current one included.
    logic         final_beat;

    assign final_beat = (state == TX_BODY) && (left == 8'd1);

    // The FIFO is read one cycle ahead, so the header beat already pops the first sample.
    assign fifo_rd = (state == TX_HEAD) || ((state == TX_BODY) && !final_beat);

    assign tx = '{valid: (state != TX_IDLE),
                  last:  final_beat,
                  data:  (state == TX_HEAD) ? {PKT_MARK, seq} : fifo_rdata};

    always_ff @(posedge sys_clk or posedge rst_run) begin
        if (rst_run) begin
            state <= TX_IDLE;
            left  <= 8'd0;
            seq   <= 8'd0;
        end else if (run_clear) begin
            state <= TX_IDLE;
            left  <= 8'd0;
            seq   <= 8'd0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (send_go) begin
                        state <= TX_HEAD;
                        left  <= pkt_count;
                    end
                end
                TX_HEAD: state <= TX_BODY;
                default: begin
                    if (final_beat) begin
                        state <= TX_IDLE;
                        seq   <= seq + 8'd1;
                    end else begin
                        left <= left - 8'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verif/acq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module acq_tb import acq_ctrl_pkg::*, acq_data_pkg::*; ();

    localparam logic [15:0] GOOD_ID     = 16'h5A17;
    localparam logic [15:0] BAD_ID      = 16'h1234;
    localparam int          PKT_TIMEOUT = 2000; // Cycles allowed for a whole packet to start.

    logic        sys_clk;
    logic        rst_run;
    logic        rx_valid;
    logic [7:0]  rx_data;
    sample_t     adc_rdata = 16'h0000;
    logic        adc_drdy  = 1'b0;
    logic        tx_done   = 1'b0;
    adc_bus_t    adc;
    tx_beat_t    tx;
    acq_status_t status;

    integer      seed;
    logic [15:0] model_id;
    sample_t     adc_sample;          // Next value the ADC model returns on a DATA read.
    sample_t     exp_sample;
    logic        cs_prev     = 1'b0;
    int          drdy_cnt    = 0;
    int          mac_wait    = 0;
    int          data_reads  = 0;
    int          conf_writes = 0;
    logic [15:0] conf_value  = 16'h0000;
    int          beat_count  = 0;
    int          run_cycles  = 0;

    acq_top #(
        .ADC_ID        (GOOD_ID),
        .RESET_CYCLES  (4),
        .ACCESS_CYCLES (2),
        .FIFO_DEPTH    (256)
    ) u_acq_top (
        .sys_clk   (sys_clk),
        .rst_run   (rst_run),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .adc_rdata (adc_rdata),
        .adc_drdy  (adc_drdy),
        .tx_done   (tx_done),
        .adc       (adc),
        .tx        (tx),
        .status    (status)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    ////////////////////////////////////////
    // ADC, MAC and stream monitors.
    ////////////////////////////////////////

    // Read data is set up at the first falling clock edge with chip select high.
    always @(negedge sys_clk) begin
        cs_prev <= adc.cs;
        if (adc.cs && !cs_prev) begin
            if (adc.rd && adc.addr == ADDR_ID) begin
                adc_rdata <= model_id;
            end else if (adc.rd && adc.addr == ADDR_DATA) begin
                adc_rdata  <= adc_sample;
                adc_sample <= adc_sample + 16'd1;
                data_reads <= data_reads + 1;
            end else if (adc.wr && adc.addr == ADDR_CONF) begin
                conf_value  <= adc.wdata;
                conf_writes <= conf_writes + 1;
            end
        end
        drdy_cnt <= (drdy_cnt == 11) ? 0 : drdy_cnt + 1;
        adc_drdy <= (drdy_cnt == 11);  // One pulse every 12 cycles.
    end

    always @(negedge sys_clk) begin
        tx_done <= (mac_wait == 1);
        if (tx.valid && tx.last) mac_wait <= 5;
        else if (mac_wait != 0) mac_wait <= mac_wait - 1;
        if (tx.valid) beat_count <= beat_count + 1;
        if (status.running) run_cycles <= run_cycles + 1;
    end

    ////////////////////////////////////////
    // Checks and bus helpers.
    ////////////////////////////////////////

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        rx_valid = 1'b1;
        rx_data  = value;
        @(negedge sys_clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_start(input logic [7:0] count, input logic [7:0] gain_byte);
        send_byte(CMD_START);
        send_byte(count);
        send_byte(gain_byte);
    endtask

    task automatic wait_running(input logic level, input int limit);
        int waited;
        waited = 0;
        while (status.running !== level) begin
            @(negedge sys_clk);
            waited++;
            if (waited > limit) report_timeout("a change of running");
        end
    endtask

    // Header first, then count samples that continue the model's series.
    task automatic collect_packet(input logic [7:0] exp_seq, input int count);
        int         waited;
        int         i;
        logic [7:0] next_seq;
        waited   = 0;
        next_seq = exp_seq + 8'd1;
        while (!tx.valid) begin
            @(negedge sys_clk);
            waited++;
            if (waited > PKT_TIMEOUT) report_timeout("a packet header");
        end
        check("tx.data header", tx.data, {PKT_MARK, exp_seq});
        check("tx.last header", tx.last, 1'b0);
        for (i = 0; i < count; i++) begin
            @(negedge sys_clk);
            check("tx.valid", tx.valid, 1'b1);
            check("tx.data", tx.data, exp_sample);
            check("tx.last", tx.last, i == count - 1);
            exp_sample = exp_sample + 16'd1;
        end
        @(negedge sys_clk);
        check("tx.valid after last", tx.valid, 1'b0);
        check("status.seq after packet", status.seq, next_seq);
    endtask

    ////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////

    task automatic check_reset_state();
        check("tx.valid", tx.valid, 1'b0);
        check("adc.cs", adc.cs, 1'b0);
        check("adc.rd", adc.rd, 1'b0);
        check("adc.wr", adc.wr, 1'b0);
        check("status.running", status.running, 1'b0);
        check("status.id_error", status.id_error, 1'b0);
        check("status.seq", status.seq, 8'h00);
    endtask

    task automatic run_first_packet();
        send_start(8'd3, 8'h27);
        wait_running(1'b1, 300);
        check("conf writes", conf_writes, 1);
        check("adc.wdata on CONF", conf_value, 16'h0027);
        collect_packet(8'd0, 3);
    endtask

    task automatic run_packet_sequence();
        collect_packet(8'd1, 3);
        collect_packet(8'd2, 3);
    endtask

    task automatic stop_and_idle();
        int waited;
        int beats;
        send_byte(CMD_STOP);
        wait_running(1'b0, 20);
        waited = 0;
        while (tx.valid) begin // A packet already framed runs to its end.
            @(negedge sys_clk);
            waited++;
            if (waited > 100) report_timeout("the packet in flight to end");
        end
        beats = beat_count;
        repeat (300) @(negedge sys_clk);
        check("tx beats after stop", beat_count, beats);
    endtask

    task automatic identity_failure();
        int waited;
        int reads;
        int beats;
        int runs;
        model_id = BAD_ID;
        reads    = data_reads;
        beats    = beat_count;
        runs     = run_cycles;
        send_start(8'd3, 8'h27);
        waited = 0;
        while (!status.id_error) begin
            @(negedge sys_clk);
            waited++;
            if (waited > 300) report_timeout("id_error to rise");
        end
        repeat (200) @(negedge sys_clk);
        check("status.running", status.running, 1'b0);
        check("cycles with running high", run_cycles, runs);
        check("DATA reads", data_reads, reads);
        check("tx beats", beat_count, beats);
        check("status.seq after run clear", status.seq, 8'h00);
    endtask

    task automatic restart_after_failure();
        model_id = GOOD_ID;
        send_start(8'd0, 8'h27);  // The DUT drops a START with an empty packet size.
        repeat (50) @(negedge sys_clk);
        check("status.id_error after empty START", status.id_error, 1'b1);
        check("status.running after empty START", status.running, 1'b0);
        exp_sample = adc_sample;
        send_start(8'd5, 8'h3C);
        wait_running(1'b1, 300);
        check("status.id_error", status.id_error, 1'b0);
        check("adc.wdata on CONF", conf_value, 16'h003C);
        collect_packet(8'd0, 5);
    endtask

    ////////////////////////////////////////
    // Run.
    ////////////////////////////////////////

    initial begin
        seed       = 32'h633d1176;
        rst_run    = 1'b1;
        rx_valid   = 1'b0;
        rx_data    = 8'h00;
        model_id   = GOOD_ID;
        adc_sample = $random(seed);
        exp_sample = adc_sample;
        repeat (10) @(negedge sys_clk);
        rst_run = 1'b0;
        check_reset_state();
        run_first_packet();
        run_packet_sequence();
        stop_and_idle();
        identity_failure();
        restart_after_failure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
